// ==== ram_ctl_pkg.sv ====
////////////////////////////////////////////////////////////
// RAM controller shared definitions
// SDRAM and VRAM address and word widths, memory depths,
// store latency and the one-hot SDRAM state encoding
////////////////////////////////////////////////////////////

`default_nettype none

package ram_ctl_pkg;

   ////////////////////////////////////////////////////////////
   // SDRAM side

   localparam int sdram_addr_width = 22;
   localparam int sdram_data_width = 32;
   // Backed words, small for simulation
   localparam int sdram_words = 4096;
   localparam int sdram_index_width = $clog2(sdram_words);

   // Cycles from read accept to completion pulse
   localparam int store_latency = 2;
   localparam int store_count_width = $clog2(store_latency + 1);

   ////////////////////////////////////////////////////////////
   // VRAM side

   localparam int vram_addr_width = 15;
   localparam int vram_data_width = 32;
   localparam int vram_words = 21504;
   localparam int vram_cpu_delay = 4;
   localparam int vram_vga_delay = 1;

   typedef logic [sdram_addr_width-1:0] sdram_addr_t;
   typedef logic [sdram_data_width-1:0] sdram_word_t;
   typedef logic [vram_addr_width-1:0] vram_addr_t;
   typedef logic [vram_data_width-1:0] vram_word_t;

   typedef enum logic [6:0] {
      sd_idle       = 7'b0000001,
      sd_read       = 7'b0000010,
      sd_read_busy  = 7'b0000100,
      sd_read_wait  = 7'b0001000,
      sd_write      = 7'b0010000,
      sd_write_busy = 7'b0100000,
      sd_write_wait = 7'b1000000
   } sdram_state_t;

endpackage

`default_nettype wire

// ==== sdram_port.sv ====
////////////////////////////////////////////////////////////
// SDRAM client port
// One-hot request FSM, store command issue, read data
// capture and the ready and done levels
////////////////////////////////////////////////////////////

`default_nettype none

module sdram_port import ram_ctl_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   input  sdram_addr_t sdram_addr,
   input  sdram_word_t sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output sdram_word_t sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,

   output logic        store_cmd_en,
   output logic        store_cmd_write,
   output sdram_addr_t store_addr,
   output sdram_word_t store_wdata,
   input  logic        store_rdy,
   input  logic        store_rd_done,
   input  sdram_word_t store_rdata
);

   sdram_state_t state;
   sdram_state_t state_next;
   logic         int_ready;
   logic         int_done;

   ////////////////////////////////////////////////////////////
   // Request FSM

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= sd_idle;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         sd_idle:
         begin
            if (sdram_req)
               state_next = sd_read;
            else if (sdram_write)
               state_next = sd_write;
         end
         sd_read:
            if (store_rdy)
               state_next = sd_read_busy;
         sd_read_busy:
            if (store_rd_done)
               state_next = sd_read_wait;
         sd_read_wait:
            if (!sdram_req)
               state_next = sd_idle;
         sd_write:
            if (store_rdy)
               state_next = sd_write_busy;
         // Store finishes a write on accept
         sd_write_busy:
            state_next = sd_write_wait;
         sd_write_wait:
            if (!sdram_write)
               state_next = sd_idle;
         default:
            state_next = sd_idle;
      endcase
   end

   // Command goes out only on the issue to busy step
   assign store_cmd_en = ((state == sd_read) || (state == sd_write)) && store_rdy;
   assign store_cmd_write = (state == sd_write);
   assign store_addr = sdram_addr;
   assign store_wdata = sdram_data_in;

   ////////////////////////////////////////////////////////////
   // Read data and completion flags

   always_ff @(posedge clk)
   begin
      if (reset)
         sdram_data_out <= '0;
      else if ((state == sd_read_busy) && store_rd_done)
         sdram_data_out <= store_rdata;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         int_ready <= 1'b0;
         int_done <= 1'b0;
      end
      else
      begin
         if (state == sd_read)
            int_ready <= 1'b0;
         else if (state == sd_read_wait)
            int_ready <= 1'b1;

         if (state == sd_write)
            int_done <= 1'b0;
         else if (state == sd_write_wait)
            int_done <= 1'b1;
      end
   end

   // Flag left over from the last access is masked outside the wait state
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sdram_ready <= 1'b0;
         sdram_done <= 1'b0;
      end
      else
      begin
         sdram_ready <= int_ready && sdram_req && (state == sd_read_wait);
         sdram_done <= int_done && sdram_write && (state == sd_write_wait);
      end
   end

endmodule

`default_nettype wire

// ==== sdram_store.sv ====
////////////////////////////////////////////////////////////
// On-chip SDRAM word store
// Command accept level, fixed-latency read completion,
// unbacked address handling
////////////////////////////////////////////////////////////

`default_nettype none

module sdram_store import ram_ctl_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        store_cmd_en,
   input  logic        store_cmd_write,
   input  sdram_addr_t store_addr,
   input  sdram_word_t store_wdata,
   output logic        store_rdy,
   output logic        store_rd_done,
   output sdram_word_t store_rdata
);

   sdram_word_t                  mem [sdram_words];
   logic [store_count_width-1:0] count;
   logic                         accept;
   logic                         backed;
   logic [sdram_index_width-1:0] index;

   assign accept = store_cmd_en && store_rdy;
   assign backed = (store_addr < sdram_addr_t'(sdram_words));
   assign index = store_addr[sdram_index_width-1:0];

   // Busy while a read is in flight
   assign store_rdy = (count == '0);
   assign store_rd_done = (count == store_count_width'(1));

   ////////////////////////////////////////////////////////////
   // Latency counter

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (accept && !store_cmd_write)
         count <= store_count_width'(store_latency);
      else if (count != '0)
         count <= count - 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Word array

   always_ff @(posedge clk)
   begin
      if (accept && store_cmd_write && backed)
         mem[index] <= store_wdata;
   end

   // Held until the completion pulse
   always_ff @(posedge clk)
   begin
      if (accept && !store_cmd_write)
      begin
         if (backed)
            store_rdata <= mem[index];
         else
            store_rdata <= '1;
      end
   end

endmodule

`default_nettype wire

// ==== vram_dpram.sv ====
////////////////////////////////////////////////////////////
// Video RAM dual-port word memory
// Side a reads and writes, side b reads only
////////////////////////////////////////////////////////////

`default_nettype none

module vram_dpram import ram_ctl_pkg::*;
(
   input  logic       clk,

   input  vram_addr_t addr_a,
   input  vram_word_t data_a,
   input  logic       wren_a,
   input  logic       rden_a,
   output vram_word_t q_a,

   input  vram_addr_t addr_b,
   input  logic       rden_b,
   output vram_word_t q_b
);

   vram_word_t mem [vram_words];

   // CPU side
   always_ff @(posedge clk)
   begin
      if (wren_a)
         mem[addr_a] <= data_a;
   end

   // Old word on a same-cycle read and write
   always_ff @(posedge clk)
   begin
      if (rden_a)
         q_a <= mem[addr_a];
   end

   // Display side
   always_ff @(posedge clk)
   begin
      if (rden_b)
         q_b <= mem[addr_b];
   end

endmodule

`default_nettype wire

// ==== vram_ports.sv ====
////////////////////////////////////////////////////////////
// VRAM port logic
// Ready delay lines for the CPU and display sides and the
// display word hold register
////////////////////////////////////////////////////////////

`default_nettype none

module vram_ports import ram_ctl_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       vram_cpu_req,
   input  logic       vram_vga_req,
   output logic       vram_cpu_ready,
   output logic       vram_vga_ready,
   input  vram_word_t vga_q,
   output vram_word_t vram_vga_data_out
);

   logic [vram_cpu_delay-1:0] cpu_dly;
   logic [vram_vga_delay-1:0] vga_dly;
   vram_word_t                vga_hold;

   ////////////////////////////////////////////////////////////
   // Request delay lines

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cpu_dly <= '0;
         vga_dly <= '0;
      end
      else
      begin
         cpu_dly <= (cpu_dly << 1) | vram_cpu_delay'(vram_cpu_req);
         vga_dly <= (vga_dly << 1) | vram_vga_delay'(vram_vga_req);
      end
   end

   assign vram_cpu_ready = cpu_dly[vram_cpu_delay-1];
   assign vram_vga_ready = vga_dly[vram_vga_delay-1];

   ////////////////////////////////////////////////////////////
   // Display hold

   always_ff @(posedge clk)
   begin
      if (reset)
         vga_hold <= '0;
      else if (vram_vga_ready)
         vga_hold <= vga_q;
   end

   // Live word while ready, last word otherwise
   assign vram_vga_data_out = vram_vga_ready ? vga_q : vga_hold;

endmodule

`default_nettype wire

// ==== ram_controller.sv ====
////////////////////////////////////////////////////////////
// RAM controller top level
// SDRAM client port with its on-chip store, and the VRAM
// with CPU and display side port logic
////////////////////////////////////////////////////////////

`default_nettype none

module ram_controller import ram_ctl_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   input  sdram_addr_t sdram_addr,
   input  sdram_word_t sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output sdram_word_t sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,

   input  vram_addr_t  vram_cpu_addr,
   input  vram_word_t  vram_cpu_data_in,
   input  logic        vram_cpu_req,
   input  logic        vram_cpu_write,
   output vram_word_t  vram_cpu_data_out,
   output logic        vram_cpu_ready,

   input  vram_addr_t  vram_vga_addr,
   input  logic        vram_vga_req,
   output vram_word_t  vram_vga_data_out,
   output logic        vram_vga_ready
);

   logic        store_cmd_en;
   logic        store_cmd_write;
   sdram_addr_t store_addr;
   sdram_word_t store_wdata;
   logic        store_rdy;
   logic        store_rd_done;
   sdram_word_t store_rdata;
   vram_word_t  vga_q;

   ////////////////////////////////////////////////////////////
   // SDRAM

   sdram_port u_sdram_port (
      .clk             (clk),
      .reset           (reset),
      .sdram_addr      (sdram_addr),
      .sdram_data_in   (sdram_data_in),
      .sdram_req       (sdram_req),
      .sdram_write     (sdram_write),
      .sdram_data_out  (sdram_data_out),
      .sdram_ready     (sdram_ready),
      .sdram_done      (sdram_done),
      .store_cmd_en    (store_cmd_en),
      .store_cmd_write (store_cmd_write),
      .store_addr      (store_addr),
      .store_wdata     (store_wdata),
      .store_rdy       (store_rdy),
      .store_rd_done   (store_rd_done),
      .store_rdata     (store_rdata)
   );

   sdram_store u_sdram_store (
      .clk             (clk),
      .reset           (reset),
      .store_cmd_en    (store_cmd_en),
      .store_cmd_write (store_cmd_write),
      .store_addr      (store_addr),
      .store_wdata     (store_wdata),
      .store_rdy       (store_rdy),
      .store_rd_done   (store_rd_done),
      .store_rdata     (store_rdata)
   );

   ////////////////////////////////////////////////////////////
   // VRAM

   vram_dpram u_vram (
      .clk    (clk),
      .addr_a (vram_cpu_addr),
      .data_a (vram_cpu_data_in),
      .wren_a (vram_cpu_write),
      .rden_a (vram_cpu_req),
      .q_a    (vram_cpu_data_out),
      .addr_b (vram_vga_addr),
      .rden_b (vram_vga_req),
      .q_b    (vga_q)
   );

   vram_ports u_vram_ports (
      .clk               (clk),
      .reset             (reset),
      .vram_cpu_req      (vram_cpu_req),
      .vram_vga_req      (vram_vga_req),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_ready    (vram_vga_ready),
      .vga_q             (vga_q),
      .vram_vga_data_out (vram_vga_data_out)
   );

endmodule

`default_nettype wire

// ==== ram_controller_tb.sv ====
////////////////////////////////////////////////////////////
// RAM controller testbench
// SDRAM and VRAM reference models, stimulus tasks,
// compare tasks and a cycle-count timeout
////////////////////////////////////////////////////////////

`default_nettype none

module ram_controller_tb import ram_ctl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int sdram_count = 16;
   localparam int vram_count = 8;
   localparam int hold_cycles = 5;
   localparam int handshake_limit = 50;
   localparam int num_ops = 2 * sdram_count + 4 + 4 + 2 * vram_count + 2;
   localparam int cycle_limit = num_ops * 20 + 200;

   logic        clk;
   logic        reset;
   sdram_addr_t sdram_addr;
   sdram_word_t sdram_data_in;
   logic        sdram_req;
   logic        sdram_write;
   sdram_word_t sdram_data_out;
   logic        sdram_ready;
   logic        sdram_done;
   vram_addr_t  vram_cpu_addr;
   vram_word_t  vram_cpu_data_in;
   logic        vram_cpu_req;
   logic        vram_cpu_write;
   vram_word_t  vram_cpu_data_out;
   logic        vram_cpu_ready;
   vram_addr_t  vram_vga_addr;
   logic        vram_vga_req;
   vram_word_t  vram_vga_data_out;
   logic        vram_vga_ready;

   // Reference models
   sdram_word_t sdram_model [sdram_addr_t];
   vram_word_t  vram_model [vram_addr_t];

   integer seed = 74;
   int     cycle_count = 0;
   int     error_count = 0;
   int     test_errors = 0;
   int     test_index = 1;
   int     tests_passed = 0;
   int     tests_failed = 0;

   ram_controller uut (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: run stopped after %0d cycles", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Expected SDRAM read

   function automatic sdram_word_t expected_sdram_read(input sdram_addr_t addr);
      if (addr >= sdram_addr_t'(sdram_words))
         return '1;
      else if (sdram_model.exists(addr))
         return sdram_model[addr];
      else
         return '0;
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare and reporting

   task automatic compare_sdram_word(input string what, input sdram_word_t got,
                                     input sdram_word_t exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic compare_vram_word(input string what, input vram_word_t got,
                                    input vram_word_t exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic compare_level(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic compare_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("[ERROR] %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic finish_test(input string name);
      if (error_count == test_errors)
      begin
         $display("Test %0d %s: ok", test_index, name);
         tests_passed++;
      end
      else
      begin
         $display("Test %0d %s: %0d errors", test_index, name, error_count - test_errors);
         tests_failed++;
      end
      test_index++;
      test_errors = error_count;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus

   // Inputs change 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic sdram_write_word(input sdram_addr_t addr, input sdram_word_t data);
      int waited;
      waited = 0;
      sdram_addr = addr;
      sdram_data_in = data;
      sdram_write = 1'b1;
      do
      begin
         next_cycle();
         waited++;
      end
      while (!sdram_done && waited < handshake_limit);
      if (!sdram_done)
         report_failure("sdram_done never rose for a write");
      sdram_model[addr] = data;
      sdram_write = 1'b0;
      next_cycle();
      compare_level("sdram_done after strobe drop", sdram_done, 1'b0);
   endtask

   // Strobe stays up for hold extra cycles after ready
   task automatic sdram_read_word(input sdram_addr_t addr, input int hold);
      int          waited;
      sdram_word_t exp_word;
      waited = 0;
      exp_word = expected_sdram_read(addr);
      sdram_addr = addr;
      sdram_req = 1'b1;
      do
      begin
         next_cycle();
         waited++;
      end
      while (!sdram_ready && waited < handshake_limit);
      if (!sdram_ready)
         report_failure("sdram_ready never rose for a read");
      compare_sdram_word($sformatf("sdram read at %h", addr), sdram_data_out, exp_word);
      for (int i = 0; i < hold; i++)
      begin
         next_cycle();
         compare_level("sdram_ready with strobe held", sdram_ready, 1'b1);
         compare_sdram_word("sdram_data_out with strobe held", sdram_data_out, exp_word);
      end
      sdram_req = 1'b0;
      next_cycle();
      compare_level("sdram_ready after strobe drop", sdram_ready, 1'b0);
   endtask

   // One-cycle request, then count edges until ready
   task automatic vram_cpu_access(input vram_addr_t addr, input logic wr,
                                  input vram_word_t data);
      int cycles;
      cycles = 0;
      vram_cpu_addr = addr;
      vram_cpu_data_in = data;
      vram_cpu_write = wr;
      vram_cpu_req = 1'b1;
      do
      begin
         next_cycle();
         cycles++;
         vram_cpu_req = 1'b0;
         vram_cpu_write = 1'b0;
      end
      while (!vram_cpu_ready && cycles < handshake_limit);
      compare_count("vram_cpu_ready delay", cycles, vram_cpu_delay);
      if (wr)
         vram_model[addr] = data;
      else
         compare_vram_word($sformatf("vram cpu read at %h", addr), vram_cpu_data_out,
                           vram_model[addr]);
   endtask

   task automatic vram_vga_read(input vram_addr_t addr);
      int cycles;
      cycles = 0;
      vram_vga_addr = addr;
      vram_vga_req = 1'b1;
      do
      begin
         next_cycle();
         cycles++;
         vram_vga_req = 1'b0;
      end
      while (!vram_vga_ready && cycles < handshake_limit);
      compare_count("vram_vga_ready delay", cycles, vram_vga_delay);
      compare_vram_word($sformatf("vram display read at %h", addr), vram_vga_data_out,
                        vram_model[addr]);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence

   initial
   begin
      sdram_addr_t sdram_used [$];
      vram_addr_t  vram_used [$];
      sdram_addr_t addr;
      vram_addr_t  vaddr;
      vram_word_t  held;

      reset = 1'b1;
      sdram_addr = '0;
      sdram_data_in = '0;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      vram_cpu_addr = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      vram_vga_addr = '0;
      vram_vga_req = 1'b0;
      repeat (2)
         @(posedge clk);
      #2;
      reset = 1'b0;

      compare_level("sdram_ready after reset", sdram_ready, 1'b0);
      compare_level("sdram_done after reset", sdram_done, 1'b0);
      compare_level("vram_cpu_ready after reset", vram_cpu_ready, 1'b0);
      compare_level("vram_vga_ready after reset", vram_vga_ready, 1'b0);
      compare_sdram_word("sdram_data_out after reset", sdram_data_out, '0);
      compare_vram_word("vram_vga_data_out after reset", vram_vga_data_out, '0);
      finish_test("reset state");

      for (int i = 0; i < sdram_count; i++)
      begin
         addr = sdram_addr_t'($unsigned($random(seed)) % sdram_words);
         sdram_write_word(addr, sdram_word_t'($random(seed)));
         sdram_used.push_back(addr);
      end
      foreach (sdram_used[i])
         sdram_read_word(sdram_used[i], 0);
      finish_test("sdram write and read-back");

      // Unbacked address whose low bits alias a backed word
      addr = sdram_addr_t'(sdram_words) + sdram_used[0];
      sdram_read_word(addr, 0);
      sdram_write_word(addr, sdram_word_t'($random(seed)));
      sdram_read_word(addr, 0);
      sdram_read_word(sdram_used[0], 0);
      finish_test("sdram unbacked address");

      sdram_write_word(sdram_addr_t'(12'h010), sdram_word_t'($random(seed)));
      sdram_write_word(sdram_addr_t'(12'h020), sdram_word_t'($random(seed)));
      sdram_read_word(sdram_addr_t'(12'h010), hold_cycles);
      sdram_read_word(sdram_addr_t'(12'h020), 0);
      finish_test("sdram held strobe");

      for (int i = 0; i < vram_count; i++)
      begin
         vaddr = vram_addr_t'($unsigned($random(seed)) % vram_words);
         vram_cpu_access(vaddr, 1'b1, vram_word_t'($random(seed)));
         vram_used.push_back(vaddr);
      end
      foreach (vram_used[i])
         vram_cpu_access(vram_used[i], 1'b0, '0);
      finish_test("vram cpu write and read");

      vaddr = vram_used[0];
      vram_vga_read(vaddr);
      // Word the display side read, before the CPU overwrites it
      held = vram_model[vaddr];
      next_cycle();
      vram_cpu_access(vaddr, 1'b1, ~held);
      repeat (3)
         next_cycle();
      compare_level("vram_vga_ready after request", vram_vga_ready, 1'b0);
      compare_vram_word("vram_vga_data_out held word", vram_vga_data_out, held);
      finish_test("vram display read and hold");

      $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ram_controller.f ====
ram_ctl_pkg.sv
sdram_port.sv
sdram_store.sv
vram_dpram.sv
vram_ports.sv
ram_controller.sv
ram_controller_tb.sv

// ==== Bender.yml ====
package:
  name: ram_controller

sources:
  - ram_ctl_pkg.sv
  - sdram_port.sv
  - sdram_store.sv
  - vram_dpram.sv
  - vram_ports.sv
  - ram_controller.sv
  - target: test
    files:
      - ram_controller_tb.sv
